// ==== Makefile ====
SRCS := $(filter-out +%,$(shell cat uart_core.f)) uart_macros.svh

.PHONY: run clean

run: obj_dir/Vtb_uart_core
	@out=$$(./obj_dir/Vtb_uart_core); \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

obj_dir/Vtb_uart_core: uart_core.f $(SRCS)
	verilator --binary --timing -j 0 --top-module tb_uart_core -f uart_core.f

clean:
	rm -rf obj_dir

// ==== tb_uart_core.sv ====
`include "uart_macros.svh"

module tb_uart_core;

    timeunit 1ns;
    timeprecision 100ps;

    import uart_pkg::*;

    localparam int BIT_CLKS = `UART_CLKS_PER_SAMPLE * `UART_OVERSAMPLE;
    localparam int TIMEOUT  = 5000;   // Cycles allowed for any single wait

    logic      clk;
    logic      reset;
    logic      cmd_valid;
    uart_cmd_t cmd;
    logic      cmd_credit;
    logic      rsp_valid;
    uart_rsp_t rsp;
    logic      rsp_credit;
    logic      rx_serial;
    logic      tx_serial;

    // Serial line model
    logic line_model;
    logic loopback;

    assign rx_serial = loopback ? tx_serial : line_model;

    int          error_count   = 0;
    int          rsp_count     = 0;
    int          credit_pulses = 0;
    int          cmd_sent      = 0;
    string       test_name     = "reset";
    logic [31:0] lfsr_state    = 32'h88db_db33;
    logic        tx_before_credit = 1'b1;   // Line level in the cycle before a credit
    uart_rsp_t   exp_queue[$];
    uart_rsp_t   exp_word;

    uart_core dut_i (
        .clk          (clk),
        .reset        (reset),
        .i_cmd_valid  (cmd_valid),
        .i_cmd        (cmd),
        .o_cmd_credit (cmd_credit),
        .o_rsp_valid  (rsp_valid),
        .o_rsp        (rsp),
        .i_rsp_credit (rsp_credit),
        .i_rx_serial  (rx_serial),
        .o_tx_serial  (tx_serial)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // ======================================
    // Reporting
    // ======================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("Failure: %s", what);
    endtask

    task automatic finish_run();
        $display("Error count %0d, responses seen %0d, command credits seen %0d",
                 error_count, rsp_count, credit_pulses);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    task automatic abort_run(input string what);
        error_count++;
        $display("Timeout while waiting for %s", what);
        finish_run();
    endtask

    // ======================================
    // Reference model and random data
    // ======================================
    function automatic uart_rsp_t expected_rsp(input logic [7:0] data, input logic stop_ok,
                                               input logic overrun);
        uart_rsp_t word;
        word.data      = data;
        word.frame_err = !stop_ok;   // Low stop bit
        word.overrun   = overrun;    // Some earlier frame was lost
        return word;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_byte(output logic [7:0] value);
        value = '0;
        repeat (8) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    // Response compare and command credit monitor
    always @(negedge clk) begin
        if (!reset && rsp_valid) begin
            rsp_count++;
            if (exp_queue.size() == 0) begin
                report_failure($sformatf("%s: response %h arrived with none expected",
                                         test_name, rsp));
            end else begin
                exp_word = exp_queue.pop_front();
                check_value(test_name, 32'(exp_word), 32'(rsp));
            end
        end
        if (!reset && cmd_credit) begin
            credit_pulses++;
            if (credit_pulses > cmd_sent) begin
                report_failure("command credit returned with no command outstanding");
            end
        end
        if (!cmd_credit) begin
            tx_before_credit = tx_serial;
        end
    end

    // ======================================
    // Host and line tasks
    // ======================================
    task automatic idle(input int cycles);
        repeat (cycles) @(posedge clk);
    endtask

    task automatic grant_rsp_credit();
        @(posedge clk);
        #1 rsp_credit = 1'b1;
        @(posedge clk);
        #1 rsp_credit = 1'b0;
    endtask

    task automatic issue_cmd(input uart_opcode_t op, input logic [7:0] data);
        int waited;
        waited = 0;
        while (1 + credit_pulses - cmd_sent <= 0) begin   // Host holds one credit
            @(posedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("a command credit before issuing");
        end
        @(posedge clk);
        #1;
        cmd_valid  = 1'b1;
        cmd.opcode = op;
        cmd.data   = data;
        cmd_sent++;
        @(posedge clk);
        #1 cmd_valid = 1'b0;
    endtask

    task automatic wait_cmd_credit(output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) abort_run("o_cmd_credit");
        end while (!cmd_credit);
    endtask

    task automatic send_byte(input logic [7:0] data);
        int lead;
        int frame_clks;
        issue_cmd(OP_SEND, data);
        lead = 0;
        do begin
            @(negedge clk);
            lead++;
        end while (tx_serial && lead < 2);
        if (tx_serial) report_failure("start bit did not begin within 2 cycles of OP_SEND");
        wait_cmd_credit(frame_clks);
        check_value("send credit after stop bit", 32'(BIT_CLKS * 10), 32'(frame_clks));
        check_value("stop bit high before credit", 32'd1, 32'(tx_before_credit));
    endtask

    task automatic hold_line(input logic value);
        line_model = value;
        repeat (BIT_CLKS) @(posedge clk);
        #1;
    endtask

    // Start, 8 data bits LSB first, stop, one idle bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        logic [7:0] shift;
        shift = data;
        @(posedge clk);
        #1;
        hold_line(1'b0);
        repeat (8) begin
            hold_line(shift[0]);
            shift = shift >> 1;
        end
        hold_line(stop_bit);
        hold_line(1'b1);
    endtask

    task automatic wait_drained(input string what);
        int waited;
        waited = 0;
        while (exp_queue.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run(what);
        end
    endtask

    task automatic wait_responses(input int target);
        int waited;
        waited = 0;
        while (rsp_count < target) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) abort_run("a credited response");
        end
    endtask

    // ======================================
    // Test sequence
    // ======================================
    initial begin
        logic [7:0] data;
        int         base;
        int         nop_clks;

        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        rsp_credit = 1'b0;
        line_model = 1'b1;
        loopback   = 1'b0;
        repeat (2) @(posedge clk);
        #1 reset = 1'b0;

        idle(20);
        @(negedge clk);
        check_value("no credit after reset", 32'd0, 32'(credit_pulses));
        check_value("tx idle after reset", 32'd1, 32'(tx_serial));
        check_value("rsp_valid low after reset", 32'd0, 32'(rsp_valid));

        test_name = "loopback";
        @(posedge clk);
        #1 loopback = 1'b1;
        repeat (6) begin
            random_byte(data);
            exp_queue.push_back(expected_rsp(data, 1'b1, 1'b0));
            grant_rsp_credit();
            send_byte(data);
        end
        wait_drained("loopback responses");
        @(posedge clk);
        #1 loopback = 1'b0;

        test_name = "frame error";
        random_byte(data);
        exp_queue.push_back(expected_rsp(data, 1'b0, 1'b0));
        grant_rsp_credit();
        send_frame(data, 1'b0);
        wait_drained("frame error response");

        test_name = "credit gating";
        base = rsp_count;
        repeat (3) begin
            random_byte(data);
            exp_queue.push_back(expected_rsp(data, 1'b1, 1'b0));
            send_frame(data, 1'b1);
        end
        check_value("gating holds responses", 32'(base), 32'(rsp_count));
        for (int i = 1; i <= 3; i++) begin
            grant_rsp_credit();
            wait_responses(base + i);
        end
        idle(200);
        check_value("gating response count", 32'(base + 3), 32'(rsp_count));

        test_name = "overrun";
        base = rsp_count;
        for (int i = 0; i < `UART_RX_FIFO_DEPTH + 2; i++) begin
            random_byte(data);
            if (i < `UART_RX_FIFO_DEPTH) begin   // Last two are dropped
                exp_queue.push_back(expected_rsp(data, 1'b1, 1'b0));
            end
            send_frame(data, 1'b1);
        end
        check_value("overrun holds responses", 32'(base), 32'(rsp_count));
        repeat (`UART_RX_FIFO_DEPTH) grant_rsp_credit();
        wait_drained("overrun drain");
        random_byte(data);
        exp_queue.push_back(expected_rsp(data, 1'b1, 1'b1));
        grant_rsp_credit();
        send_frame(data, 1'b1);
        wait_drained("entry after overrun");
        idle(200);
        check_value("overrun response count", 32'(base + 5), 32'(rsp_count));

        test_name = "nop credit";
        repeat (2) begin
            issue_cmd(OP_NOP, 8'h00);
            wait_cmd_credit(nop_clks);
            check_value("nop credit latency", 32'd1, 32'(nop_clks));
        end
        idle(100);
        check_value("one credit per command", 32'(cmd_sent), 32'(credit_pulses));
        check_value("expected words left", 32'd0, 32'(exp_queue.size()));
        finish_run();
    end

endmodule

// ==== uart_core.f ====
+incdir+.
uart_pkg.sv
uart_rx_path.sv
uart_tx_path.sv
uart_ctrl.sv
uart_core.sv
tb_uart_core.sv

// ==== uart_core.sv ====
`include "uart_macros.svh"

module uart_core (
    input  logic                clk,
    input  logic                reset,
    input  logic                i_cmd_valid,
    input  uart_pkg::uart_cmd_t i_cmd,
    output logic                o_cmd_credit,
    output logic                o_rsp_valid,
    output uart_pkg::uart_rsp_t o_rsp,
    input  logic                i_rsp_credit,
    input  logic                i_rx_serial,
    output logic                o_tx_serial
);

    // Receive path handshake
    logic                       byte_ready;
    logic [`UART_WORD_SIZE-1:0] rx_byte;
    logic                       frame_err;
    logic                       ack;

    // Transmit path handshake
    logic                       tx_start;
    logic [`UART_WORD_SIZE-1:0] tx_byte;
    logic                       tx_done;

    uart_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_cmd_credit (o_cmd_credit),
        .i_rsp_credit (i_rsp_credit),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .i_byte_ready (byte_ready),
        .i_byte       (rx_byte),
        .i_frame_err  (frame_err),
        .o_ack        (ack),
        .o_tx_start   (tx_start),
        .o_tx_byte    (tx_byte),
        .i_tx_done    (tx_done)
    );

    uart_rx_path u_rx_path (
        .clk          (clk),
        .reset        (reset),
        .i_rx_serial  (i_rx_serial),
        .i_ack        (ack),
        .o_byte_ready (byte_ready),
        .o_byte       (rx_byte),
        .o_frame_err  (frame_err)
    );

    uart_tx_path u_tx_path (
        .clk         (clk),
        .reset       (reset),
        .i_tx_start  (tx_start),
        .i_tx_byte   (tx_byte),
        .o_tx_serial (o_tx_serial),
        .o_tx_done   (tx_done)
    );

endmodule

// ==== uart_ctrl.sv ====
`include "uart_macros.svh"

module uart_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_cmd_valid,
    input  uart_pkg::uart_cmd_t        i_cmd,
    output logic                       o_cmd_credit,
    input  logic                       i_rsp_credit,
    output logic                       o_rsp_valid,
    output uart_pkg::uart_rsp_t        o_rsp,
    input  logic                       i_byte_ready,
    input  logic [`UART_WORD_SIZE-1:0] i_byte,
    input  logic                       i_frame_err,
    output logic                       o_ack,
    output logic                       o_tx_start,
    output logic [`UART_WORD_SIZE-1:0] o_tx_byte,
    input  logic                       i_tx_done
);

    import uart_pkg::*;

    localparam int DEPTH    = `UART_RX_FIFO_DEPTH;
    localparam int PTR_W    = $clog2(DEPTH);
    localparam int CREDIT_W = 8;

    // ======================================
    // Command decode
    // ======================================
    logic cmd_send;
    logic cmd_nop;
    logic nop_credit;

    always_comb begin
        cmd_send = 1'b0;
        cmd_nop  = 1'b0;
        if (i_cmd_valid) begin
            case (i_cmd.opcode)
                OP_SEND: cmd_send = 1'b1;
                OP_NOP:  cmd_nop  = 1'b1;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_tx_start <= 1'b0;
            nop_credit <= 1'b0;
        end else begin
            o_tx_start <= cmd_send;
            nop_credit <= cmd_nop;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_send) o_tx_byte <= i_cmd.data;
    end

    // Never both at once, the host holds only one credit
    assign o_cmd_credit = nop_credit | i_tx_done;

    // ======================================
    // Receive FIFO and response credits
    // ======================================
    uart_rsp_t           fifo_mem [DEPTH];
    uart_rsp_t           push_entry;
    logic [PTR_W:0]      wr_ptr;
    logic [PTR_W:0]      rd_ptr;
    logic [CREDIT_W-1:0] credit_count;
    logic                overrun_pending;
    logic                fifo_empty;
    logic                fifo_full;
    logic                push;
    logic                pop;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                        (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign o_ack      = i_byte_ready;   // Always taken, dropped if full
    assign push       = i_byte_ready && !fifo_full;
    assign pop        = (credit_count != '0) && !fifo_empty;

    assign push_entry.data      = i_byte;
    assign push_entry.frame_err = i_frame_err;
    assign push_entry.overrun   = overrun_pending;

    always_ff @(posedge clk) begin
        if (push) fifo_mem[wr_ptr[PTR_W-1:0]] <= push_entry;
        if (pop)  o_rsp <= fifo_mem[rd_ptr[PTR_W-1:0]];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            credit_count    <= '0;
            overrun_pending <= 1'b0;
            o_rsp_valid     <= 1'b0;
        end else begin
            o_rsp_valid  <= pop;
            credit_count <= credit_count + CREDIT_W'(i_rsp_credit) - CREDIT_W'(pop);
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
            if (i_byte_ready && fifo_full) begin
                overrun_pending <= 1'b1;   // Sticky until next push
            end else if (push) begin
                overrun_pending <= 1'b0;
            end
        end
    end

endmodule

// ==== uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// ======================================
// Baud timing
// ======================================

// Clock cycles per oversample tick
`define UART_CLKS_PER_SAMPLE 4

// Oversample ticks per bit, 64 clocks per bit with the divisor above
`define UART_OVERSAMPLE 16

// ======================================
// Frame and buffering
// ======================================

`define UART_WORD_SIZE 8       // Data bits per frame
`define UART_RX_FIFO_DEPTH 4   // Power of two

`endif

// ==== uart_pkg.sv ====
`include "uart_macros.svh"

package uart_pkg;

    // Receive FSM
    typedef enum logic [2:0] {
        RX_IDLE,
        RX_VALIDATE_START,
        RX_READ_DATA,
        RX_STOP,
        RX_DATA_READY
    } uart_rx_state_t;

    // Transmit FSM
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_t;

    typedef enum logic {
        OP_NOP  = 1'b0,   // Returns the command credit only
        OP_SEND = 1'b1    // Transmit the data byte
    } uart_opcode_t;

    typedef struct packed {
        uart_opcode_t                opcode;
        logic [`UART_WORD_SIZE-1:0] data;
    } uart_cmd_t;

    typedef struct packed {
        logic [`UART_WORD_SIZE-1:0] data;
        logic                        frame_err;  // Stop bit was low
        logic                        overrun;    // A frame was dropped before this one
    } uart_rsp_t;

endpackage

// ==== uart_rx_path.sv ====
`include "uart_macros.svh"

module uart_rx_path (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_rx_serial,
    input  logic                       i_ack,
    output logic                       o_byte_ready,
    output logic [`UART_WORD_SIZE-1:0] o_byte,
    output logic                       o_frame_err
);

    import uart_pkg::*;

    localparam int TIMER_W  = $clog2(`UART_CLKS_PER_SAMPLE);
    localparam int SAMPLE_W = $clog2(`UART_OVERSAMPLE);
    localparam int BIT_W    = $clog2(`UART_WORD_SIZE);

    // ======================================
    // Input synchronizer
    // ======================================
    logic rx_meta;
    logic rx_sync;

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;   // Line idles high
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx_serial;
            rx_sync <= rx_meta;
        end
    end

    // ======================================
    // Oversampling timer
    // ======================================
    uart_rx_state_t      state;
    uart_rx_state_t      next_state;
    logic [TIMER_W-1:0]  clk_count;
    logic [SAMPLE_W-1:0] sample_count;
    logic                timer_run;
    logic                timer_clear;
    logic                sample_tick;
    logic                mid_bit;
    logic                end_bit;

    assign timer_run   = (state == RX_VALIDATE_START) || (state == RX_READ_DATA) ||
                         (state == RX_STOP);
    assign sample_tick = timer_run && (clk_count == TIMER_W'(`UART_CLKS_PER_SAMPLE - 1));
    assign mid_bit     = sample_tick && (sample_count == SAMPLE_W'(`UART_OVERSAMPLE / 2 - 1));
    assign end_bit     = sample_tick && (sample_count == SAMPLE_W'(`UART_OVERSAMPLE - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_count    <= '0;
            sample_count <= '0;
        end else if (timer_clear) begin
            clk_count    <= '0;
            sample_count <= '0;
        end else if (sample_tick) begin
            clk_count    <= '0;
            sample_count <= sample_count + 1'b1;   // Wraps at end of bit
        end else if (timer_run) begin
            clk_count <= clk_count + 1'b1;
        end
    end

    // ======================================
    // Receive FSM
    // ======================================
    logic [BIT_W-1:0]           bit_count;
    logic [`UART_WORD_SIZE-1:0] shift_reg;
    logic                       shift_en;
    logic                       stop_check;

    always_comb begin
        next_state  = state;
        timer_clear = 1'b0;
        shift_en    = 1'b0;
        stop_check  = 1'b0;
        case (state)
            RX_IDLE: begin
                if (!rx_sync) begin   // Falling edge of start bit
                    next_state  = RX_VALIDATE_START;
                    timer_clear = 1'b1;
                end
            end
            RX_VALIDATE_START: begin
                if (mid_bit) begin
                    if (!rx_sync) begin
                        next_state  = RX_READ_DATA;
                        timer_clear = 1'b1;   // Later samples land mid-bit
                    end else begin
                        next_state = RX_IDLE;   // Glitch
                    end
                end
            end
            RX_READ_DATA: begin
                if (end_bit) begin
                    shift_en = 1'b1;
                    if (bit_count == BIT_W'(`UART_WORD_SIZE - 1)) begin
                        next_state = RX_STOP;
                    end
                end
            end
            RX_STOP: begin
                if (end_bit) begin
                    stop_check = 1'b1;
                    next_state = RX_DATA_READY;   // Bad stop bit is reported too
                end
            end
            RX_DATA_READY: begin
                if (i_ack) begin
                    next_state = RX_IDLE;
                end
            end
            default: next_state = RX_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= RX_IDLE;
            bit_count   <= '0;
            o_frame_err <= 1'b0;
        end else begin
            state <= next_state;
            if (shift_en) begin
                bit_count <= bit_count + 1'b1;
            end else if (state == RX_IDLE) begin
                bit_count <= '0;
            end
            if (stop_check) begin
                o_frame_err <= !rx_sync;
            end else if (i_ack) begin
                o_frame_err <= 1'b0;
            end
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (shift_en) begin
            shift_reg <= {rx_sync, shift_reg[`UART_WORD_SIZE-1:1]};
        end
    end

    assign o_byte       = shift_reg;
    assign o_byte_ready = (state == RX_DATA_READY);

endmodule

// ==== uart_tx_path.sv ====
`include "uart_macros.svh"

module uart_tx_path (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       i_tx_start,
    input  logic [`UART_WORD_SIZE-1:0] i_tx_byte,
    output logic                       o_tx_serial,
    output logic                       o_tx_done
);

    import uart_pkg::*;

    localparam int CLKS_PER_BIT = `UART_CLKS_PER_SAMPLE * `UART_OVERSAMPLE;
    localparam int TIMER_W      = $clog2(CLKS_PER_BIT);
    localparam int BIT_W        = $clog2(`UART_WORD_SIZE);

    uart_tx_state_t             state;
    logic [TIMER_W-1:0]         baud_count;
    logic [BIT_W-1:0]           bit_count;
    logic [`UART_WORD_SIZE-1:0] shift_reg;
    logic                       bit_tick;

    assign bit_tick = (baud_count == TIMER_W'(CLKS_PER_BIT - 1));

    // ======================================
    // Baud timer
    // ======================================
    always_ff @(posedge clk) begin
        if (reset) begin
            baud_count <= '0;
        end else if ((state == TX_IDLE) || bit_tick) begin
            baud_count <= '0;
        end else begin
            baud_count <= baud_count + 1'b1;
        end
    end

    // ======================================
    // Transmit FSM
    // ======================================
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= TX_IDLE;
            bit_count <= '0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;   // Single cycle pulse
            case (state)
                TX_IDLE: if (i_tx_start) state <= TX_START;
                TX_START: begin
                    if (bit_tick) begin
                        state     <= TX_DATA;
                        bit_count <= '0;
                    end
                end
                TX_DATA: begin
                    if (bit_tick) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == BIT_W'(`UART_WORD_SIZE - 1)) begin
                            state <= TX_STOP;
                        end
                    end
                end
                TX_STOP: begin
                    if (bit_tick) begin
                        state     <= TX_IDLE;
                        o_tx_done <= 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if ((state == TX_IDLE) && i_tx_start) begin
            shift_reg <= i_tx_byte;
        end else if ((state == TX_DATA) && bit_tick) begin
            shift_reg <= shift_reg >> 1;   // Next bit to LSB
        end
    end

    always_comb begin
        case (state)
            TX_START: o_tx_serial = 1'b0;
            TX_DATA:  o_tx_serial = shift_reg[0];
            default:  o_tx_serial = 1'b1;   // Idle and stop bit
        endcase
    end

endmodule
